// File: Makefile
# Verilator build, run and lint for the streaming MAC testbench

TOP := tb_mac_stream
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary -j 0 -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -qF "*** TEST FAILED ***" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
+incdir+hdl
hdl/mac_pkg.sv
hdl/spill_cell_cu.sv
hdl/spill_cell.sv
hdl/mul_stage.sv
hdl/acc_stage.sv
hdl/mac_stream_top.sv
bench/tb_mac_stream.sv

// File: bench/tb_mac_stream.sv
// Directed testbench for the streaming MAC with reference model, monitor and watchdog
`timescale 1ns/1ps
`include "mac_defs.svh"

module tb_mac_stream import mac_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    // Worst case operand count over all tests
    localparam int TOTAL_OPS   = 1 + 16 * 8 + 24 * 4 + 3 + 300 + 5 + 4;
    localparam int TIMEOUT_CYC = TOTAL_OPS * 20 + 2000;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  flush_i;
    logic                  op_valid_i;
    logic [`MAC_OP_W-1:0]  op_a_i;
    logic [`MAC_OP_W-1:0]  op_b_i;
    logic                  op_last_i;
    logic                  op_ready_o;
    logic                  res_ready_i;
    logic                  res_valid_o;
    logic [`MAC_ACC_W-1:0] res_sum_o;
    logic [`MAC_CNT_W-1:0] res_count_o;

    integer      seed;
    // Own stream for the ready toggling
    integer      rdy_seed;
    logic [31:0] rnd;
    logic [31:0] rdy_rnd;
    logic        rdy_random = 1'b0;
    // Expected results in arrival order
    result_t     exp_q[$];
    result_t     mon_exp;
    int          pass_cnt   = 0;
    int          fail_cnt   = 0;
    int          mon_pass   = 0;
    int          mon_fail   = 0;
    int          stall_cnt  = 0;

    mac_stream_top dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .op_valid_i  (op_valid_i),
        .op_a_i      (op_a_i),
        .op_b_i      (op_b_i),
        .op_last_i   (op_last_i),
        .op_ready_o  (op_ready_o),
        .res_ready_i (res_ready_i),
        .res_valid_o (res_valid_o),
        .res_sum_o   (res_sum_o),
        .res_count_o (res_count_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Result ready held high or toggled at random
    initial begin
        res_ready_i = 1'b1;
        rdy_seed    = 32'hb74a;
        forever begin
            @(posedge clk_i);
            #1;
            if (rdy_random) begin
                rdy_rnd     = $random(rdy_seed);
                res_ready_i = (rdy_rnd[2:0] == 3'd0);
            end else begin
                res_ready_i = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Monitor sampled mid cycle where handshake signals are stable
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_n_i && res_valid_o && res_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: a result came out with no vector pending", $time);
                mon_fail++;
            end else begin
                mon_exp = exp_q.pop_front();
                if (res_sum_o !== mon_exp.sum) begin
                    report_mismatch("res_sum_o", 64'(mon_exp.sum), 64'(res_sum_o));
                    mon_fail++;
                end else begin
                    mon_pass++;
                end
                if (res_count_o !== mon_exp.count) begin
                    report_mismatch("res_count_o", 64'(mon_exp.count), 64'(res_count_o));
                    mon_fail++;
                end else begin
                    mon_pass++;
                end
            end
        end
    end

    // Operand input stalled while the result output is held off
    always @(negedge clk_i) begin
        if (rst_n_i && !op_ready_o && res_valid_o && !res_ready_i) begin
            stall_cnt++;
        end
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("[FAIL] %0t %s expected 0x%0h actual 0x%0h", $time, sig, exp_v, act_v);
    endtask

    // Holds one operand pair until the DUT takes it and returns 1 ns after that edge
    task automatic send_op(input logic [`MAC_OP_W-1:0] a, input logic [`MAC_OP_W-1:0] b,
                           input logic last);
        logic taken;
        op_valid_i = 1'b1;
        op_a_i     = a;
        op_b_i     = b;
        op_last_i  = last;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = op_ready_o;
            @(posedge clk_i);
            #1;
        end
    endtask

    // One vector where a closed vector queues its reference result
    task automatic send_vector(input int len, input logic all_max, input logic close);
        logic [`MAC_OP_W-1:0] a;
        logic [`MAC_OP_W-1:0] b;
        logic [63:0]          acc;
        result_t              exp_res;
        acc = '0;
        for (int i = 0; i < len; i++) begin
            if (all_max) begin
                a = '1;
                b = '1;
            end else begin
                rnd = $random(seed);
                a   = rnd[`MAC_OP_W-1:0];
                b   = rnd[2*`MAC_OP_W-1:`MAC_OP_W];
            end
            acc = acc + 64'(a) * 64'(b);
            send_op(a, b, close && (i == len - 1));
        end
        if (close) begin
            // Truncation gives the modulo of both fields
            exp_res.sum   = acc[`MAC_ACC_W-1:0];
            exp_res.count = len[`MAC_CNT_W-1:0];
            exp_q.push_back(exp_res);
        end
    endtask

    task automatic wait_drain();
        int guard;
        guard      = 0;
        op_valid_i = 1'b0;
        op_last_i  = 1'b0;
        while (exp_q.size() != 0 && guard < 4000) begin
            @(posedge clk_i);
            #1;
            guard++;
        end
        if (exp_q.size() != 0) begin
            $display("Error at %0t: %0d results never came out", $time, exp_q.size());
            fail_cnt++;
        end
        // Quiet stretch to catch extra results
        repeat (8) @(posedge clk_i);
        #1;
    endtask

    task automatic end_test(input int num, input string name, input int p0, input int f0);
        $display("Test %0d %s: %0d checks passed, %0d failed", num, name,
                 pass_cnt + mon_pass - p0, fail_cnt + mon_fail - f0);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic test_single();
        int   p0;
        int   f0;
        int   lat;
        logic seen;
        p0 = pass_cnt + mon_pass;
        f0 = fail_cnt + mon_fail;
        // First cycle out of reset
        if (op_ready_o !== 1'b0) begin
            report_mismatch("op_ready_o", 64'd0, 64'(op_ready_o));
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
        @(posedge clk_i);
        #1;
        if (op_ready_o !== 1'b1) begin
            report_mismatch("op_ready_o", 64'd1, 64'(op_ready_o));
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
        if (res_valid_o !== 1'b0) begin
            report_mismatch("res_valid_o", 64'd0, 64'(res_valid_o));
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
        send_vector(1, 1'b0, 1'b1);
        op_valid_i = 1'b0;
        op_last_i  = 1'b0;
        // Cycles from the last operand edge to res_valid_o
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < 50) begin
            @(negedge clk_i);
            if (res_valid_o) begin
                seen = 1'b1;
            end else begin
                @(posedge clk_i);
                #1;
                lat++;
            end
        end
        if (!seen) begin
            $display("Error at %0t: no result for the single element vector", $time);
            fail_cnt++;
        end else if (lat != 4) begin
            report_mismatch("res_valid_o latency", 64'd4, 64'(lat));
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
        wait_drain();
        end_test(1, "single element after reset", p0, f0);
    endtask

    task automatic test_back_to_back();
        int p0;
        int f0;
        p0 = pass_cnt + mon_pass;
        f0 = fail_cnt + mon_fail;
        for (int v = 0; v < 16; v++) begin
            rnd = $random(seed);
            send_vector(1 + int'(rnd[2:0]), 1'b0, 1'b1);
        end
        wait_drain();
        end_test(2, "back-to-back random vectors", p0, f0);
    endtask

    task automatic test_backpressure();
        int p0;
        int f0;
        int stalls0;
        p0         = pass_cnt + mon_pass;
        f0         = fail_cnt + mon_fail;
        stalls0    = stall_cnt;
        rdy_random = 1'b1;
        // Short vectors so results pile up behind the slow sink
        for (int v = 0; v < 24; v++) begin
            rnd = $random(seed);
            send_vector(1 + int'(rnd[1:0]), 1'b0, 1'b1);
        end
        wait_drain();
        rdy_random = 1'b0;
        if (stall_cnt == stalls0) begin
            $display("Error at %0t: op_ready_o never fell under back-pressure", $time);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
        end_test(3, "random result back-pressure", p0, f0);
    endtask

    task automatic test_wrap();
        int p0;
        int f0;
        p0 = pass_cnt + mon_pass;
        f0 = fail_cnt + mon_fail;
        send_vector(3, 1'b1, 1'b1);
        // Long enough to wrap both the sum and the count
        send_vector(300, 1'b1, 1'b1);
        wait_drain();
        end_test(4, "maximum operands wrap", p0, f0);
    endtask

    task automatic test_flush();
        int p0;
        int f0;
        p0 = pass_cnt + mon_pass;
        f0 = fail_cnt + mon_fail;
        send_vector(5, 1'b0, 1'b0);
        // Partial vector still in the pipeline
        op_valid_i = 1'b0;
        flush_i    = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        send_vector(4, 1'b0, 1'b1);
        wait_drain();
        end_test(5, "flush mid vector", p0, f0);
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        seed       = 32'hb74a;
        rst_n_i    = 1'b0;
        flush_i    = 1'b0;
        op_valid_i = 1'b0;
        op_a_i     = '0;
        op_b_i     = '0;
        op_last_i  = 1'b0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        test_single();
        test_back_to_back();
        test_backpressure();
        test_wrap();
        test_flush();
        $display("Summary: %0d checks passed, %0d failed",
                 pass_cnt + mon_pass, fail_cnt + mon_fail);
        if (fail_cnt + mon_fail == 0 && pass_cnt + mon_pass > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: hdl/acc_stage.sv
// Accumulate stage summing products and emitting one result per vector
`timescale 1ns/1ps
`include "mac_defs.svh"

module acc_stage import mac_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    flush_i,
    // Product stream in
    input  logic    valid_i,
    input  prod_t   prod_i,
    output logic    ready_o,
    // Result stream out
    input  logic    ready_i,
    output logic    valid_o,
    output result_t result_o
);

    // ------------------------------------------------------------------------
    // Running state
    // ------------------------------------------------------------------------
    logic [`MAC_ACC_W-1:0] sum_q;
    logic [`MAC_CNT_W-1:0] cnt_q;
    // Last product taken, result goes out next cycle
    logic                  pend_q;
    logic                  valid_q;
    result_t               res_q;
    logic [`MAC_ACC_W-1:0] prod_ext;
    logic                  in_xfer;

    // Zero extend product into the accumulator width
    assign prod_ext = {{(`MAC_ACC_W - `MAC_PROD_W){1'b0}}, prod_i.prod};

    // No new input while a result is on its way out
    assign ready_o = ~pend_q & ~valid_q;
    assign in_xfer = valid_i & ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sum_q   <= '0;
            cnt_q   <= '0;
            pend_q  <= 1'b0;
            valid_q <= 1'b0;
        end else if (flush_i) begin
            // Drop partial vector and any pending result
            sum_q   <= '0;
            cnt_q   <= '0;
            pend_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (in_xfer) begin
                // Sum wraps modulo 2**MAC_ACC_W
                sum_q  <= sum_q + prod_ext;
                cnt_q  <= cnt_q + 1'b1;
                pend_q <= prod_i.last;
            end else if (pend_q) begin
                // Result latched, restart from zero
                sum_q   <= '0;
                cnt_q   <= '0;
                pend_q  <= 1'b0;
                valid_q <= 1'b1;
            end else if (valid_q && ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Result register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (pend_q) begin
            res_q.sum   <= sum_q;
            res_q.count <= cnt_q;
        end
    end

    assign valid_o  = valid_q;
    assign result_o = res_q;

endmodule

// File: hdl/mac_defs.svh
// Width and configuration macros for the streaming MAC datapath
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// Operand width of each input lane
`define MAC_OP_W 16

// Full product, no truncation
`define MAC_PROD_W (2 * `MAC_OP_W)

// Accumulator width, sums wrap at this size
`define MAC_ACC_W 40

// Element counter width, count wraps too
`define MAC_CNT_W 8

// Result buffer bypass, 1 turns the result spill cell into wires
`define MAC_RES_SKIP 1'b0

`endif

// File: hdl/mac_pkg.sv
// Payload structs and spill cell FSM state type for the MAC datapath
`include "mac_defs.svh"

package mac_pkg;

    // ------------------------------------------------------------------------
    // Stream payloads
    // ------------------------------------------------------------------------

    // Product from the multiply stage
    typedef struct packed {
        logic [`MAC_PROD_W-1:0] prod;
        // Closes the current vector
        logic                   last;
    } prod_t;

    // One dot product result per vector
    typedef struct packed {
        logic [`MAC_ACC_W-1:0]  sum;
        logic [`MAC_CNT_W-1:0]  count;
    } result_t;

    // ------------------------------------------------------------------------
    // Spill cell control
    // ------------------------------------------------------------------------

    // Occupancy of the two-entry buffer
    typedef enum logic [1:0] {
        EMPTY,
        HALF,
        FULL
    } spill_state_e;

endpackage

// File: hdl/mac_stream_top.sv
// Top level of the streaming dot product unit, multiply to accumulate chain
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_stream_top import mac_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    // Operand stream
    input  logic                  op_valid_i,
    input  logic [`MAC_OP_W-1:0]  op_a_i,
    input  logic [`MAC_OP_W-1:0]  op_b_i,
    input  logic                  op_last_i,
    output logic                  op_ready_o,
    // Result stream
    input  logic                  res_ready_i,
    output logic                  res_valid_o,
    output logic [`MAC_ACC_W-1:0] res_sum_o,
    output logic [`MAC_CNT_W-1:0] res_count_o
);

    // ------------------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------------------

    // Multiplier to product buffer
    logic    mul_valid;
    prod_t   mul_prod;
    logic    pspill_ready;
    // Product buffer to accumulator
    logic    pspill_valid;
    prod_t   pspill_prod;
    logic    acc_ready;
    // Accumulator to result buffer
    logic    acc_valid;
    result_t acc_result;
    logic    rspill_ready;
    // Result buffer payload
    result_t res_data;

    mul_stage u_mul (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (op_valid_i),
        .op_a_i  (op_a_i),
        .op_b_i  (op_b_i),
        .last_i  (op_last_i),
        .ready_o (op_ready_o),
        .ready_i (pspill_ready),
        .valid_o (mul_valid),
        .prod_o  (mul_prod)
    );

    spill_cell #(.DATA_T(prod_t), .SKIP(1'b0)) u_prod_spill (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (mul_valid),
        .ready_i (acc_ready),
        .valid_o (pspill_valid),
        .ready_o (pspill_ready),
        .data_i  (mul_prod),
        .data_o  (pspill_prod)
    );

    acc_stage u_acc (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .valid_i  (pspill_valid),
        .prod_i   (pspill_prod),
        .ready_o  (acc_ready),
        .ready_i  (rspill_ready),
        .valid_o  (acc_valid),
        .result_o (acc_result)
    );

    spill_cell #(.DATA_T(result_t), .SKIP(`MAC_RES_SKIP)) u_res_spill (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (acc_valid),
        .ready_i (res_ready_i),
        .valid_o (res_valid_o),
        .ready_o (rspill_ready),
        .data_i  (acc_result),
        .data_o  (res_data)
    );

    // Unpack result fields onto the ports
    assign res_sum_o   = res_data.sum;
    assign res_count_o = res_data.count;

endmodule

// File: hdl/mul_stage.sv
// Registered multiply stage turning operand pairs into tagged products
`timescale 1ns/1ps
`include "mac_defs.svh"

module mul_stage import mac_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    // Operand stream in
    input  logic                 valid_i,
    input  logic [`MAC_OP_W-1:0] op_a_i,
    input  logic [`MAC_OP_W-1:0] op_b_i,
    input  logic                 last_i,
    output logic                 ready_o,
    // Product stream out
    input  logic                 ready_i,
    output logic                 valid_o,
    output prod_t                prod_o
);

    logic                   valid_q;
    prod_t                  prod_q;
    logic [`MAC_PROD_W-1:0] mul_res;
    // Holds off input for one cycle after reset
    logic                   run_q;
    logic                   in_xfer;

    // Unsigned, full width
    assign mul_res = op_a_i * op_b_i;

    // Free slot or the slot empties this cycle
    assign ready_o = run_q & (~valid_q | ready_i);
    assign in_xfer = valid_i & ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // Output valid flag
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (in_xfer) begin
            valid_q <= 1'b1;
        end else if (ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // Product register, held while stalled
    always_ff @(posedge clk_i) begin
        if (in_xfer) begin
            prod_q.prod <= mul_res;
            prod_q.last <= last_i;
        end
    end

    assign valid_o = valid_q;
    assign prod_o  = prod_q;

endmodule

// File: hdl/spill_cell.sv
// Two-entry spill cell with a type-parameterized payload and an optional bypass
`timescale 1ns/1ps

module spill_cell #(
    parameter type DATA_T = logic,
    // Set to turn the cell into plain wires
    parameter bit  SKIP   = 1'b0
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,
    // Handshake
    input  logic  valid_i,
    input  logic  ready_i,
    output logic  valid_o,
    output logic  ready_o,
    // Payload
    input  DATA_T data_i,
    output DATA_T data_o
);

    if (SKIP) begin : gen_skip

        // Zero latency pass-through
        assign valid_o = valid_i;
        assign ready_o = ready_i;
        assign data_o  = data_i;

    end else begin : gen_cell

        // --------------------------------------------------------------------
        // Control
        // --------------------------------------------------------------------
        logic  a_en;
        logic  b_en;
        logic  b_sel;
        DATA_T a_data_q;
        DATA_T b_data_q;

        spill_cell_cu u_cu (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .flush_i (flush_i),
            .valid_i (valid_i),
            .ready_o (ready_o),
            .ready_i (ready_i),
            .valid_o (valid_o),
            .a_en_o  (a_en),
            .b_en_o  (b_en),
            .b_sel_o (b_sel)
        );

        // --------------------------------------------------------------------
        // Datapath
        // --------------------------------------------------------------------

        // Main register
        always_ff @(posedge clk_i) begin
            if (a_en) begin
                a_data_q <= data_i;
            end
        end

        // Spill register, loaded while downstream stalls
        always_ff @(posedge clk_i) begin
            if (b_en) begin
                b_data_q <= data_i;
            end
        end

        // Oldest item goes out first
        assign data_o = b_sel ? b_data_q : a_data_q;

    end

endmodule

// File: hdl/spill_cell_cu.sv
// Spill cell control FSM driving the handshake and the data register enables
`timescale 1ns/1ps

module spill_cell_cu import mac_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    // Upstream side
    input  logic valid_i,
    output logic ready_o,
    // Downstream side
    input  logic ready_i,
    output logic valid_o,
    // Datapath control
    output logic a_en_o,
    output logic b_en_o,
    output logic b_sel_o
);

    spill_state_e state_q;
    spill_state_e next_state;
    // Register holding the oldest item, 1 means B
    logic         b_sel_q;
    logic         b_sel_d;
    logic         ready_q;
    logic         in_xfer;

    // Input transfer only when the registered ready is up
    assign in_xfer = valid_i & ready_q;

    // ------------------------------------------------------------------------
    // Next state and register enables
    // ------------------------------------------------------------------------
    always_comb begin
        next_state = state_q;
        b_sel_d    = b_sel_q;
        a_en_o     = 1'b0;
        b_en_o     = 1'b0;
        case (state_q)
            EMPTY: begin
                // First item always lands in A
                if (in_xfer) begin
                    a_en_o     = 1'b1;
                    b_sel_d    = 1'b0;
                    next_state = HALF;
                end
            end
            HALF: begin
                if (ready_i) begin
                    // Head leaves, a new item replaces it in A
                    if (in_xfer) begin
                        a_en_o  = 1'b1;
                        b_sel_d = 1'b0;
                    end else begin
                        next_state = EMPTY;
                    end
                end else if (in_xfer) begin
                    // Stall, spill into the free register
                    if (b_sel_q) begin
                        a_en_o = 1'b1;
                    end else begin
                        b_en_o = 1'b1;
                    end
                    next_state = FULL;
                end
            end
            FULL: begin
                // Head drained, the other register is next
                if (ready_i) begin
                    b_sel_d    = ~b_sel_q;
                    next_state = HALF;
                end
            end
            default: next_state = EMPTY;
        endcase
    end

    // ------------------------------------------------------------------------
    // State registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= EMPTY;
            b_sel_q <= 1'b0;
            // Low for the first cycle out of reset
            ready_q <= 1'b0;
        end else if (flush_i) begin
            state_q <= EMPTY;
            b_sel_q <= 1'b0;
            ready_q <= 1'b1;
        end else begin
            state_q <= next_state;
            b_sel_q <= b_sel_d;
            ready_q <= (next_state != FULL);
        end
    end

    assign valid_o = (state_q != EMPTY);
    assign ready_o = ready_q;
    assign b_sel_o = b_sel_q;

endmodule
